/* had_bkpt_macros.svh */
// Breakpoint unit constants

`ifndef HAD_BKPT_MACROS_SVH
`define HAD_BKPT_MACROS_SVH

// Number of instructions the core can retire in one cycle.
`define HAD_RETIRE_NUM 3

// Width of the breakpoint match nibble reported per retire slot.
// Bits 1 and 2 belong to group A, bits 0 and 3 to group B.
`define HAD_MATCH_W 4

`endif

/* had_bkpt_pkg.sv */
// Breakpoint unit types

package had_bkpt_pkg;

  // One registered retire cycle after slot qualification and group reduction.
  typedef struct packed {
    logic a_hit;       // Some retiring slot matched bit 1 or bit 2.
    logic b_hit;       // Some retiring slot matched bit 0 or bit 3.
    logic retire0;     // Slot 0 retired normally.
    logic split;       // The retiring instruction is split.
    logic flush;       // The pipeline is flushed.
    logic dbgon;       // The core is in debug mode.
    logic any_retire;  // At least one slot retired.
  } retire_bkpt_t;

  // Breakpoint event handed from the processing stage to the request logic.
  typedef struct packed {
    logic vld;
    logic is_a;
  } bkpt_event_t;

  // Cause reported together with the debug request.
  typedef enum logic [1:0] {
    none  = 2'd0,
    grp_a = 2'd1,
    grp_b = 2'd2
  } bkpt_cause_e;

endpackage

/* had_retire_qual.sv */
// Retire breakpoint qualifier

`timescale 1ns/10ps
`include "had_bkpt_macros.svh"

module had_retire_qual
  import had_bkpt_pkg::*;
(
  input  logic                    cpuclk,
  input  logic                    cpurst_b,
  input  logic [`HAD_MATCH_W-1:0] inst0_match,
  input  logic [`HAD_MATCH_W-1:0] inst1_match,
  input  logic [`HAD_MATCH_W-1:0] inst2_match,
  input  logic                    retire0_normal,
  input  logic                    retire1,
  input  logic                    retire2,
  input  logic                    split_inst,
  input  logic                    dbgon,
  input  logic                    flush,
  output retire_bkpt_t            rtr
);

  logic [`HAD_MATCH_W-1:0]    match_raw [`HAD_RETIRE_NUM];
  logic [`HAD_RETIRE_NUM-1:0] retire;
  logic                       a_hit_c;
  logic                       b_hit_c;
  retire_bkpt_t               rtr_d;

  assign match_raw[0] = inst0_match;
  assign match_raw[1] = inst1_match;
  assign match_raw[2] = inst2_match;

  assign retire = {retire2, retire1, retire0_normal};

  // A slot only contributes its match bits in a cycle where it retires.
  always_comb
  begin
    a_hit_c = 1'b0;
    b_hit_c = 1'b0;
    for (int i = 0; i < `HAD_RETIRE_NUM; i++)
    begin
      if (retire[i])
      begin
        a_hit_c = a_hit_c | match_raw[i][1] | match_raw[i][2];
        b_hit_c = b_hit_c | match_raw[i][0] | match_raw[i][3];
      end
    end
  end

  always_comb
  begin
    rtr_d.a_hit      = a_hit_c;
    rtr_d.b_hit      = b_hit_c;
    rtr_d.retire0    = retire0_normal;
    rtr_d.split      = split_inst;
    rtr_d.flush      = flush;
    rtr_d.dbgon      = dbgon;
    rtr_d.any_retire = |retire;
  end

  // Flush and debug-on go through the same register as the hits,
  // so the later stages see them in the retire cycle they belong to.
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rtr <= '0;
    else
      rtr <= rtr_d;
  end

  // A group hit can only come from a slot that actually retired.
  a_hit_needs_retire: assert property (
    @(posedge cpuclk) disable iff (!cpurst_b)
    (rtr.a_hit || rtr.b_hit) |-> rtr.any_retire
  ) else $error("group hit without a retiring slot");

endmodule

/* had_nirv_bkpt.sv */
// Non-intrusive breakpoint stage

`timescale 1ns/10ps

module had_nirv_bkpt
  import had_bkpt_pkg::*;
(
  input  logic         cpuclk,
  input  logic         cpurst_b,
  input  retire_bkpt_t rtr,
  input  logic         ctrl_bkpta_en,
  input  logic         ctrl_bkptb_en,
  input  logic         nirven,
  output bkpt_event_t  evt
);

  logic qual_a;
  logic qual_b;
  logic bkpt_occur;
  logic occur_raw;
  logic bkpt_pending;
  logic bkpta_pending;
  logic is_a_sel;
  logic vld_q;
  logic is_a_q;

  // Each group is gated by its own enable and by the global enable.
  assign qual_a     = rtr.a_hit & ctrl_bkpta_en;
  assign qual_b     = rtr.b_hit & ctrl_bkptb_en;
  assign bkpt_occur = nirven & (qual_a | qual_b);

  // A hit on a split instruction waits for its last part.
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      bkpt_pending <= 1'b0;
    else if (rtr.flush)
      bkpt_pending <= 1'b0;
    else if (bkpt_occur && rtr.split)
      bkpt_pending <= 1'b1;
    else if (rtr.dbgon)
      bkpt_pending <= 1'b0;
  end

  // Only the first split hit decides the group.
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      bkpta_pending <= 1'b0;
    else if (bkpt_occur && rtr.split && !bkpt_pending)
      bkpta_pending <= rtr.a_hit;
    else if (rtr.dbgon)
      bkpta_pending <= 1'b0;
  end

  // Either a plain hit, or the non-split retire that closes a pending split.
  assign occur_raw = (bkpt_occur && !rtr.split) ||
                     (bkpt_pending && rtr.retire0 && !rtr.split);

  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      vld_q <= 1'b0;
    else if (rtr.flush)
      vld_q <= 1'b0;
    else if (occur_raw)
      vld_q <= 1'b1;
    else if (rtr.dbgon)
      vld_q <= 1'b0;
  end

  assign is_a_sel = bkpt_pending ? bkpta_pending : rtr.a_hit;

  // The group is frozen once the event is valid.
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      is_a_q <= 1'b0;
    else if (occur_raw && !vld_q)
      is_a_q <= is_a_sel;
    else if (rtr.dbgon)
      is_a_q <= 1'b0;
  end

  assign evt.vld  = vld_q;
  assign evt.is_a = is_a_q;

  // A flushed retire cycle never leaves a valid breakpoint behind.
  no_vld_after_flush: assert property (
    @(posedge cpuclk) disable iff (!cpurst_b)
    rtr.flush |=> !evt.vld
  ) else $error("breakpoint valid after flush");

endmodule

/* had_dbg_req_ctrl.sv */
// Debug request control

`timescale 1ns/10ps

module had_dbg_req_ctrl
  import had_bkpt_pkg::*;
(
  input  logic         cpuclk,
  input  logic         cpurst_b,
  input  bkpt_event_t  evt,
  input  retire_bkpt_t rtr,
  output logic         dbg_req,
  output bkpt_cause_e  bkpt_cause
);

  logic vld_q;
  logic vld_rise;

  // Previous value of the event valid, for edge detection.
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      vld_q <= 1'b0;
    else
      vld_q <= evt.vld;
  end

  // A new breakpoint is ignored once the core is already in debug mode.
  assign vld_rise = evt.vld && !vld_q && !rtr.dbgon;

  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      dbg_req <= 1'b0;
    else if (rtr.dbgon)
      dbg_req <= 1'b0;
    else if (rtr.flush)
      dbg_req <= 1'b0;
    else if (vld_rise)
      dbg_req <= 1'b1;
  end

  // The cause survives a flush and is only cleared on debug entry.
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      bkpt_cause <= none;
    else if (rtr.dbgon)
      bkpt_cause <= none;
    else if (!rtr.flush && vld_rise)
      bkpt_cause <= evt.is_a ? grp_a : grp_b;
  end

  // The request must not be raised while debug mode is active.
  no_req_in_dbgon: assert property (
    @(posedge cpuclk) disable iff (!cpurst_b)
    rtr.dbgon |=> !dbg_req
  ) else $error("debug request raised in debug mode");

endmodule

/* had_bkpt_top.sv */
// Breakpoint unit top level

`timescale 1ns/10ps
`include "had_bkpt_macros.svh"

module had_bkpt_top
  import had_bkpt_pkg::*;
(
  input  logic                    cpuclk,
  input  logic                    cpurst_b,
  input  logic                    ctrl_bkpta_en,
  input  logic                    ctrl_bkptb_en,
  input  logic                    nirven,
  input  logic [`HAD_MATCH_W-1:0] inst0_match,
  input  logic [`HAD_MATCH_W-1:0] inst1_match,
  input  logic [`HAD_MATCH_W-1:0] inst2_match,
  input  logic                    retire0_normal,
  input  logic                    retire1,
  input  logic                    retire2,
  input  logic                    split_inst,
  input  logic                    dbgon,
  input  logic                    flush,
  output logic                    dbg_req,
  output bkpt_cause_e             bkpt_cause
);

  retire_bkpt_t rtr;
  bkpt_event_t  evt;

  // Input register and group reduction.
  had_retire_qual u_had_retire_qual (
    .cpuclk         (cpuclk),
    .cpurst_b       (cpurst_b),
    .inst0_match    (inst0_match),
    .inst1_match    (inst1_match),
    .inst2_match    (inst2_match),
    .retire0_normal (retire0_normal),
    .retire1        (retire1),
    .retire2        (retire2),
    .split_inst     (split_inst),
    .dbgon          (dbgon),
    .flush          (flush),
    .rtr            (rtr)
  );

  // Enable gating and split handling.
  had_nirv_bkpt u_had_nirv_bkpt (
    .cpuclk        (cpuclk),
    .cpurst_b      (cpurst_b),
    .rtr           (rtr),
    .ctrl_bkpta_en (ctrl_bkpta_en),
    .ctrl_bkptb_en (ctrl_bkptb_en),
    .nirven        (nirven),
    .evt           (evt)
  );

  // Request level and cause.
  had_dbg_req_ctrl u_had_dbg_req_ctrl (
    .cpuclk     (cpuclk),
    .cpurst_b   (cpurst_b),
    .evt        (evt),
    .rtr        (rtr),
    .dbg_req    (dbg_req),
    .bkpt_cause (bkpt_cause)
  );

endmodule

/* had_bkpt_tb.sv */
// Breakpoint unit testbench

`timescale 1ns/10ps
`include "had_bkpt_macros.svh"

module had_bkpt_tb
  import had_bkpt_pkg::*;
;

  localparam int CLK_PERIOD      = 20;
  localparam int DIRECTED_CYCLES = 120;
  localparam int RANDOM_CYCLES   = 2000;
  localparam int MARGIN_CYCLES   = 200;
  localparam int WATCHDOG_NS     =
    (4 + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  logic                    cpuclk;
  logic                    cpurst_b;
  logic                    ctrl_bkpta_en;
  logic                    ctrl_bkptb_en;
  logic                    nirven;
  logic [`HAD_MATCH_W-1:0] inst0_match;
  logic [`HAD_MATCH_W-1:0] inst1_match;
  logic [`HAD_MATCH_W-1:0] inst2_match;
  logic                    retire0_normal;
  logic                    retire1;
  logic                    retire2;
  logic                    split_inst;
  logic                    dbgon;
  logic                    flush;
  logic                    dbg_req;
  bkpt_cause_e             bkpt_cause;

  // Reference model state, one variable per register of the breakpoint path.
  retire_bkpt_t m_rtr;
  logic         m_pend;
  logic         m_pend_a;
  logic         m_vld;
  logic         m_is_a;
  logic         m_vld_q;
  logic         m_req;
  bkpt_cause_e  m_cause;

  int          model_errors;
  int          directed_errors;
  int          checks;
  logic [31:0] rnd;

  had_bkpt_top u_had_bkpt_top (
    .cpuclk         (cpuclk),
    .cpurst_b       (cpurst_b),
    .ctrl_bkpta_en  (ctrl_bkpta_en),
    .ctrl_bkptb_en  (ctrl_bkptb_en),
    .nirven         (nirven),
    .inst0_match    (inst0_match),
    .inst1_match    (inst1_match),
    .inst2_match    (inst2_match),
    .retire0_normal (retire0_normal),
    .retire1        (retire1),
    .retire2        (retire2),
    .split_inst     (split_inst),
    .dbgon          (dbgon),
    .flush          (flush),
    .dbg_req        (dbg_req),
    .bkpt_cause     (bkpt_cause)
  );

  initial cpuclk = 1'b0;

  always #(CLK_PERIOD / 2) cpuclk = ~cpuclk;

  // Advances the model by the rising edge that just passed, using the inputs still held.
  task automatic model_step();
    logic occ;
    logic occ_raw;
    logic rise;
    occ = nirven & ((m_rtr.a_hit & ctrl_bkpta_en) | (m_rtr.b_hit & ctrl_bkptb_en));
    occ_raw = (occ & ~m_rtr.split) | (m_pend & m_rtr.retire0 & ~m_rtr.split);
    rise = m_vld & ~m_vld_q & ~m_rtr.dbgon;
    // Request stage sees the old event.
    if (m_rtr.dbgon)
    begin
      m_req   = 1'b0;
      m_cause = none;
    end
    else if (m_rtr.flush)
      m_req = 1'b0;
    else if (rise)
    begin
      m_req   = 1'b1;
      m_cause = m_is_a ? grp_a : grp_b;
    end
    m_vld_q = m_vld;
    if (occ_raw && !m_vld)
      m_is_a = m_pend ? m_pend_a : m_rtr.a_hit;
    else if (m_rtr.dbgon)
      m_is_a = 1'b0;
    if (occ && m_rtr.split && !m_pend)
      m_pend_a = m_rtr.a_hit;
    else if (m_rtr.dbgon)
      m_pend_a = 1'b0;
    if (m_rtr.flush)
      m_vld = 1'b0;
    else if (occ_raw)
      m_vld = 1'b1;
    else if (m_rtr.dbgon)
      m_vld = 1'b0;
    if (m_rtr.flush)
      m_pend = 1'b0;
    else if (occ && m_rtr.split)
      m_pend = 1'b1;
    else if (m_rtr.dbgon)
      m_pend = 1'b0;
    // Group A is match bits 1 and 2, group B is bits 0 and 3.
    m_rtr.a_hit = (retire0_normal & (inst0_match[1] | inst0_match[2])) |
                  (retire1 & (inst1_match[1] | inst1_match[2])) |
                  (retire2 & (inst2_match[1] | inst2_match[2]));
    m_rtr.b_hit = (retire0_normal & (inst0_match[0] | inst0_match[3])) |
                  (retire1 & (inst1_match[0] | inst1_match[3])) |
                  (retire2 & (inst2_match[0] | inst2_match[3]));
    m_rtr.retire0    = retire0_normal;
    m_rtr.split      = split_inst;
    m_rtr.flush      = flush;
    m_rtr.dbgon      = dbgon;
    m_rtr.any_retire = retire0_normal | retire1 | retire2;
  endtask

  task automatic compare_model();
    checks++;
    assert (dbg_req === m_req)
    else
    begin
      model_errors++;
      $display("Fail at %0t: dbg_req expected %0b got %0b", $time, m_req, dbg_req);
    end
    assert (bkpt_cause === m_cause)
    else
    begin
      model_errors++;
      $display("Fail at %0t: bkpt_cause expected %0d got %0d", $time, m_cause, bkpt_cause);
    end
  endtask

  // Waits for the next falling edge, where outputs are stable and inputs change.
  task automatic next_cycle();
    @(negedge cpuclk);
    model_step();
    compare_model();
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic expect_out(input logic exp_req, input bkpt_cause_e exp_cause);
    checks++;
    assert (dbg_req === exp_req)
    else
    begin
      directed_errors++;
      $display("Fail at %0t: dbg_req expected %0b got %0b", $time, exp_req, dbg_req);
    end
    assert (bkpt_cause === exp_cause)
    else
    begin
      directed_errors++;
      $display("Fail at %0t: bkpt_cause expected %0d got %0d", $time, exp_cause, bkpt_cause);
    end
  endtask

  task automatic set_idle();
    inst0_match    = '0;
    inst1_match    = '0;
    inst2_match    = '0;
    retire0_normal = 1'b0;
    retire1        = 1'b0;
    retire2        = 1'b0;
    split_inst     = 1'b0;
    flush          = 1'b0;
    dbgon          = 1'b0;
  endtask

  // A one-cycle debug-on pulse clears the request and the cause.
  task automatic enter_debug();
    dbgon = 1'b1;
    next_cycle();
    dbgon = 1'b0;
    next_cycle();
    expect_out(1'b0, none);
    next_cycle();
  endtask

  // A single hit, then checks the request exactly three edges later.
  task automatic hit_and_expect(input logic [3:0] nib, input bkpt_cause_e exp_cause);
    inst1_match = nib;
    retire1     = 1'b1;
    next_cycle();
    set_idle();
    next_cycle();
    expect_out(1'b0, none);
    next_cycle();
    expect_out(1'b1, exp_cause);
  endtask

  task automatic drive_random();
    rnd = $urandom;
    inst0_match    = rnd[3:0];
    inst1_match    = rnd[7:4];
    inst2_match    = rnd[11:8];
    retire0_normal = rnd[12];
    retire1        = rnd[13];
    retire2        = rnd[14];
    split_inst     = (rnd[17:15] == 3'd0);
    flush          = (rnd[21:18] == 4'd0);
    dbgon          = (rnd[26:22] == 5'd0);
    if (rnd[31:28] == 4'd0)
      ctrl_bkpta_en = ~ctrl_bkpta_en;
    rnd = $urandom;
    if (rnd[3:0] == 4'd0)
      ctrl_bkptb_en = ~ctrl_bkptb_en;
    nirven = (rnd[9:5] != 5'd0);
  endtask

  initial
  begin
    void'($urandom(32'h31d4));
    model_errors    = 0;
    directed_errors = 0;
    checks          = 0;
    m_rtr    = '0;
    m_pend   = 1'b0;
    m_pend_a = 1'b0;
    m_vld    = 1'b0;
    m_is_a   = 1'b0;
    m_vld_q  = 1'b0;
    m_req    = 1'b0;
    m_cause  = none;
    ctrl_bkpta_en = 1'b1;
    ctrl_bkptb_en = 1'b1;
    nirven        = 1'b1;
    set_idle();
    cpurst_b = 1'b0;
    repeat (4) @(negedge cpuclk);
    cpurst_b = 1'b1;

    // Plain hits of each group.
    hit_and_expect(4'b0010, grp_a);
    enter_debug();
    hit_and_expect(4'b1000, grp_b);
    enter_debug();

    // Global enable low, then each group enable low.
    nirven = 1'b0;
    inst2_match = 4'b0100;
    retire2     = 1'b1;
    next_cycle();
    set_idle();
    wait_cycles(3);
    expect_out(1'b0, none);
    nirven = 1'b1;
    ctrl_bkpta_en = 1'b0;
    inst2_match = 4'b0100;
    retire2     = 1'b1;
    next_cycle();
    set_idle();
    wait_cycles(3);
    expect_out(1'b0, none);
    ctrl_bkpta_en = 1'b1;
    ctrl_bkptb_en = 1'b0;
    inst0_match    = 4'b0001;
    retire0_normal = 1'b1;
    next_cycle();
    set_idle();
    wait_cycles(3);
    expect_out(1'b0, none);
    ctrl_bkptb_en = 1'b1;

    // Split hit A, then split hit B, closed by a plain retire0.
    retire0_normal = 1'b1;
    split_inst     = 1'b1;
    inst0_match    = 4'b0010;
    next_cycle();
    inst0_match = 4'b0001;
    next_cycle();
    set_idle();
    wait_cycles(3);
    expect_out(1'b0, none);
    retire0_normal = 1'b1;
    next_cycle();
    set_idle();
    next_cycle();
    expect_out(1'b0, none);
    next_cycle();
    expect_out(1'b1, grp_a);
    enter_debug();

    // Flush right after a hit.
    inst1_match = 4'b0100;
    retire1     = 1'b1;
    next_cycle();
    set_idle();
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    wait_cycles(3);
    expect_out(1'b0, none);

    // Flush while a split hit is pending.
    retire0_normal = 1'b1;
    split_inst     = 1'b1;
    inst0_match    = 4'b1000;
    next_cycle();
    set_idle();
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    retire0_normal = 1'b1;
    next_cycle();
    set_idle();
    wait_cycles(3);
    expect_out(1'b0, none);

    // A flush drops the request but keeps the cause until debug-on.
    hit_and_expect(4'b0001, grp_b);
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    next_cycle();
    expect_out(1'b0, grp_b);
    enter_debug();

    repeat (RANDOM_CYCLES)
    begin
      drive_random();
      next_cycle();
    end

    $display("Checks: %0d, model errors: %0d, directed errors: %0d",
             checks, model_errors, directed_errors);
    if (model_errors == 0 && directed_errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  // Ends a run that stops making progress.
  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish in %0d ns", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* had_bkpt.f */
+incdir+.
had_bkpt_pkg.sv
had_retire_qual.sv
had_nirv_bkpt.sv
had_dbg_req_ctrl.sv
had_bkpt_top.sv
had_bkpt_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the breakpoint unit simulation with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --timescale 1ns/10ps \
  --top-module had_bkpt_tb \
  -f had_bkpt.f \
  -o sim_had_bkpt

./obj_dir/sim_had_bkpt 2>&1 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
